/* sim/tb_wr_link_trace.txt */
# op and its fields in hex
# aw: id size len burst addr blocked  w: id data strb last blocked
# credit: channel (0 aw, 1 w) pulses  b: id resp  drop: no fields
aw 0 2 00 1 00001000 0
aw 1 2 03 1 00002040 0
aw 2 3 0f 1 80000100 0
aw 3 2 00 0 0000fffc 1
w 0 deadbeef f 1 0
w 1 01234567 3 0 0
w 1 89abcdef c 1 0
w 2 a5a5a5a5 f 1 0
w 3 5a5a5a5a 1 1 1
b 0 0
b 1 2
credit 0 2
aw 3 2 00 0 0000fffc 0
aw 0 1 07 2 12345678 0
aw 1 2 01 1 00000010 1
credit 1 1
w 3 5a5a5a5a 1 1 0
b 2 1
b 3 3
b 0 1
drop

/* list.f */
+incdir+design
design/link_pkg.sv
design/phy_lane_if.sv
design/online_sync.sv
design/ll_transmit.sv
design/ll_receive.sv
design/phy_framer.sv
design/axi_wr_link_top.sv
sim/tb_axi_wr_link.sv

/* Bender.yml */
package:
  name: axi_wr_link

export_include_dirs:
  - design

sources:
  - files:
      - design/link_pkg.sv
      - design/phy_lane_if.sv
      - design/online_sync.sv
      - design/ll_transmit.sv
      - design/ll_receive.sv
      - design/phy_framer.sv
      - design/axi_wr_link_top.sv
  - target: simulation
    files:
      - sim/tb_axi_wr_link.sv

/* sim/tb_axi_wr_link.sv */
module tb_axi_wr_link;

  localparam int CLK_PERIOD      = 40;
  localparam int BLOCK_CYCLES    = 8;
  localparam int CYCLES_PER_LINE = 50;

  logic        clk_wr;
  logic        rst_n;
  logic        tx_online;
  logic        rx_online;
  logic [15:0] delay_value;
  logic [7:0]  init_aw_credit;
  logic [7:0]  init_w_credit;
  logic [95:0] tx_phy;
  logic [95:0] rx_phy;
  logic [1:0]  awid;
  logic [2:0]  awsize;
  logic [7:0]  awlen;
  logic [1:0]  awburst;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [1:0]  wid;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bid;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;

  // Parsed trace
  logic [63:0]      op_q[$];
  logic [5:0][31:0] arg_q[$];

  // Expected traffic and the cycle each item was handed over
  logic [46:0] aw_exp_q[$];
  logic [38:0] w_exp_q[$];
  logic [3:0]  b_exp_q[$];
  int          aw_cyc_q[$];
  int          w_cyc_q[$];
  int          pop_cyc_q[$];

  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          b_popped = 0;
  int          b_credits = 0;
  int          run_limit = 0;
  int unsigned seed;
  bit          hold_b = 1'b0;

  axi_wr_link_top u_dut (.*);

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic report_mismatch(input string name, input logic [95:0] exp,
                                 input logic [95:0] act);
    errors++;
    $display("Fail t=%0t %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error t=%0t %s", $time, msg);
  endtask

  task automatic next_drive();
    @(posedge clk_wr);
    #2;
  endtask

  function automatic int field_count(input logic [63:0] op);
    if (op == "aw") return 6;
    if (op == "w") return 5;
    if (op == "credit" || op == "b") return 2;
    return 0;
  endfunction

  // A lone # token starts a comment up to the end of the line
  task automatic load_trace();
    int               fd;
    int               ch;
    int               k;
    logic [63:0]      op;
    logic [31:0]      val;
    logic [5:0][31:0] args;
    fd = $fopen("sim/tb_wr_link_trace.txt", "r");
    if (fd == 0) begin
      report_error("cannot open the trace file");
      return;
    end
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        ch = 0;
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        args = '0;
        for (k = 0; k < field_count(op); k++) begin
          if ($fscanf(fd, "%h", val) == 1) args[k] = val;
        end
        op_q.push_back(op);
        arg_q.push_back(args);
      end
    end
    $fclose(fd);
  endtask

  task automatic bring_up();
    int i;
    int waited;
    tx_online = 1'b1;
    rx_online = 1'b1;
    for (i = 1; i < 5; i++) begin
      next_drive();
      checks++;
      if (awready !== 1'b0) report_mismatch("awready", 0, awready);
    end
    waited = 0;
    while (awready !== 1'b1 && waited < 2) begin
      next_drive();
      waited++;
    end
    checks++;
    if (awready !== 1'b1) report_error("awready did not rise within 2 cycles of the hold-off");
  endtask

  // Present one AW or W word; a blocked word must see ready stay low
  task automatic offer(input bit is_w, input logic [46:0] word, input bit blocked);
    int acc;
    if (is_w) begin
      {wid, wdata, wstrb, wlast} = word[38:0];
      wvalid = 1'b1;
    end else begin
      {awid, awsize, awlen, awburst, awaddr} = word;
      awvalid = 1'b1;
    end
    if (blocked) begin
      repeat (BLOCK_CYCLES) begin
        checks++;
        if ((is_w ? wready : awready) !== 1'b0) begin
          report_mismatch(is_w ? "wready" : "awready", 0, is_w ? wready : awready);
        end
        next_drive();
      end
    end else begin
      while ((is_w ? wready : awready) !== 1'b1) begin
        next_drive();
      end
      acc = cyc;
      next_drive();
      if (is_w) begin
        w_exp_q.push_back(word[38:0]);
        w_cyc_q.push_back(acc);
      end else begin
        aw_exp_q.push_back(word);
        aw_cyc_q.push_back(acc);
      end
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic pulse_credit(input bit is_w, input int count);
    repeat (count) begin
      rx_phy = '0;
      rx_phy[is_w ? 6 : 5] = 1'b1;
      next_drive();
    end
    rx_phy = '0;
  endtask

  task automatic push_b(input logic [3:0] word);
    rx_phy      = '0;
    rx_phy[4:1] = word;
    rx_phy[0]   = 1'b1;
    b_exp_q.push_back(word);
    next_drive();
    rx_phy = '0;
  endtask

  task automatic drop_link();
    while (aw_exp_q.size() + w_exp_q.size() + b_exp_q.size() != 0) begin
      next_drive();
    end
    repeat (4) next_drive();
    checks++;
    if (b_credits != b_popped) report_mismatch("b credit count", b_popped, b_credits);
    // One credit per channel and one response left waiting in the FIFO
    hold_b      = 1'b1;
    rx_phy      = '0;
    rx_phy[6:5] = 2'b11;
    rx_phy[4:1] = 4'h6;
    rx_phy[0]   = 1'b1;
    next_drive();
    rx_phy = '0;
    next_drive();
    checks++;
    if (awready !== 1'b1) report_mismatch("awready", 1, awready);
    if (wready !== 1'b1) report_mismatch("wready", 1, wready);
    if (bvalid !== 1'b1) report_mismatch("bvalid", 1, bvalid);
    // Words accepted on the dropping edge never reach tx_phy
    awvalid   = 1'b1;
    wvalid    = 1'b1;
    rx_online = 1'b0;
    repeat (2) next_drive();
    repeat (BLOCK_CYCLES) begin
      checks++;
      if (awready !== 1'b0) report_mismatch("awready", 0, awready);
      if (wready !== 1'b0) report_mismatch("wready", 0, wready);
      if (bvalid !== 1'b0) report_mismatch("bvalid", 0, bvalid);
      if (tx_phy !== '0) report_mismatch("tx_phy", 0, tx_phy);
      next_drive();
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  // Pushes match queued words in order, 2 cycles after hand-over
  task automatic check_tx_phy();
    logic [46:0] exp_aw;
    logic [38:0] exp_w;
    int          acc;
    if (tx_phy[95:89] !== '0) report_mismatch("tx_phy[95:89]", 0, tx_phy[95:89]);
    if (tx_phy[0] === 1'b1) begin
      checks++;
      if (aw_exp_q.size() == 0) begin
        report_error("AW push in tx_phy without an accepted AW");
      end else begin
        exp_aw = aw_exp_q.pop_front();
        acc    = aw_cyc_q.pop_front();
        if (tx_phy[47:1] !== exp_aw) report_mismatch("tx_phy aw word", exp_aw, tx_phy[47:1]);
        if (cyc - acc != 2) report_mismatch("aw latency", 2, cyc - acc);
      end
    end
    if (tx_phy[48] === 1'b1) begin
      checks++;
      if (w_exp_q.size() == 0) begin
        report_error("W push in tx_phy without an accepted W");
      end else begin
        exp_w = w_exp_q.pop_front();
        acc   = w_cyc_q.pop_front();
        if (tx_phy[87:49] !== exp_w) report_mismatch("tx_phy w word", exp_w, tx_phy[87:49]);
        if (cyc - acc != 2) report_mismatch("w latency", 2, cyc - acc);
      end
    end
    if (tx_phy[88] === 1'b1) begin
      b_credits++;
      if (pop_cyc_q.size() == 0) begin
        report_error("B credit in tx_phy without a popped response");
      end else begin
        acc = pop_cyc_q.pop_front();
        if (cyc - acc != 2) report_mismatch("b credit latency", 2, cyc - acc);
      end
    end
  endtask

  //////////////////////////////
  // Processes
  //////////////////////////////

  initial begin
    forever begin
      @(posedge clk_wr);
      #1;
      cyc++;
      check_tx_phy();
    end
  end

  // B sink with random back-pressure
  initial begin
    logic [3:0] exp_b;
    seed = $urandom(13296);
    forever begin
      next_drive();
      bready = !hold_b && (($urandom % 4) != 0);
      if (bvalid === 1'b1 && bready) begin
        checks++;
        if (b_exp_q.size() == 0) begin
          report_error("bvalid high with no response outstanding");
        end else begin
          exp_b = b_exp_q.pop_front();
          if (bid !== exp_b[3:2]) report_mismatch("bid", exp_b[3:2], bid);
          if (bresp !== exp_b[1:0]) report_mismatch("bresp", exp_b[1:0], bresp);
          pop_cyc_q.push_back(cyc);
          b_popped++;
        end
      end
    end
  end

  initial begin
    wait (run_limit > 0);
    repeat (run_limit) @(posedge clk_wr);
    $display("Timeout after %0d cycles, the trace did not finish", run_limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [63:0]      op;
    logic [5:0][31:0] args;
    int               idx;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_value    = 16'd5;
    init_aw_credit = 8'd3;
    init_w_credit  = 8'd4;
    rx_phy         = '0;
    {awid, awsize, awlen, awburst, awaddr, awvalid} = '0;
    {wid, wdata, wstrb, wlast, wvalid} = '0;
    bready         = 1'b0;
    load_trace();
    // Two extra lines of budget for reset and bring-up
    run_limit = (op_q.size() + 2) * CYCLES_PER_LINE;
    repeat (4) @(posedge clk_wr);
    #2;
    rst_n = 1'b1;
    repeat (2) next_drive();
    bring_up();
    for (idx = 0; idx < op_q.size(); idx++) begin
      op   = op_q[idx];
      args = arg_q[idx];
      if (op == "aw") begin
        offer(1'b0, {args[0][1:0], args[1][2:0], args[2][7:0], args[3][1:0], args[4]},
              args[5][0]);
      end else if (op == "w") begin
        offer(1'b1, {args[0][1:0], args[1], args[2][3:0], args[3][0]}, args[4][0]);
      end else if (op == "credit") begin
        pulse_credit(args[0][0], args[1]);
      end else if (op == "b") begin
        push_b({args[0][1:0], args[1][1:0]});
      end else if (op == "drop") begin
        drop_link();
      end else begin
        report_error("unknown operation in the trace");
      end
    end
    repeat (4) next_drive();
    if (aw_exp_q.size() + w_exp_q.size() + b_exp_q.size() != 0) begin
      report_error("expected traffic still outstanding at the end of the trace");
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* design/axi_wr_link_top.sv */
`include "link_settings.svh"

module axi_wr_link_top (
  input  logic                clk_wr,
  input  logic                rst_n,

  // Link control
  input  logic                tx_online,
  input  logic                rx_online,
  input  link_pkg::delay_t    delay_value,
  input  link_pkg::credit_t   init_aw_credit,
  input  link_pkg::credit_t   init_w_credit,

  // PHY words
  output link_pkg::phy_word_t tx_phy,
  input  link_pkg::phy_word_t rx_phy,

  // AXI AW
  input  logic [1:0]          awid,
  input  logic [2:0]          awsize,
  input  logic [7:0]          awlen,
  input  logic [1:0]          awburst,
  input  logic [31:0]         awaddr,
  input  logic                awvalid,
  output logic                awready,

  // AXI W
  input  logic [1:0]          wid,
  input  logic [31:0]         wdata,
  input  logic [3:0]          wstrb,
  input  logic                wlast,
  input  logic                wvalid,
  output logic                wready,

  // AXI B
  output logic [1:0]          bid,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready
);

  logic               link_up;
  link_pkg::aw_word_t aw_word;
  link_pkg::w_word_t  w_word;
  link_pkg::b_word_t  b_word;

  phy_lane_if u_lane ();

  //////////////////////////////
  // Field packing
  //////////////////////////////

  assign aw_word     = {awid, awsize, awlen, awburst, awaddr};
  assign w_word      = {wid, wdata, wstrb, wlast};
  assign {bid, bresp} = b_word;

  online_sync u_sync (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_online   (tx_online),
    .rx_online   (rx_online),
    .delay_value (delay_value),
    .link_up     (link_up)
  );

  //////////////////////////////
  // Link channels
  //////////////////////////////

  ll_transmit #(.WIDTH(`LINK_AW_WIDTH)) u_tx_aw (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .link_up       (link_up),
    .init_credit   (init_aw_credit),
    .user_valid    (awvalid),
    .user_data     (aw_word),
    .user_ready    (awready),
    .push          (u_lane.aw_push),
    .data          (u_lane.aw_data),
    .credit_return (u_lane.aw_credit)
  );

  ll_transmit #(.WIDTH(`LINK_W_WIDTH)) u_tx_w (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .link_up       (link_up),
    .init_credit   (init_w_credit),
    .user_valid    (wvalid),
    .user_data     (w_word),
    .user_ready    (wready),
    .push          (u_lane.w_push),
    .data          (u_lane.w_data),
    .credit_return (u_lane.w_credit)
  );

  ll_receive #(.WIDTH(`LINK_B_WIDTH), .DEPTH(`LINK_B_DEPTH)) u_rx_b (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .link_up    (link_up),
    .push       (u_lane.b_push),
    .data       (u_lane.b_data),
    .user_valid (bvalid),
    .user_data  (b_word),
    .user_ready (bready),
    .credit     (u_lane.b_credit)
  );

  phy_framer u_framer (
    .clk_wr  (clk_wr),
    .rst_n   (rst_n),
    .link_up (link_up),
    .lane    (u_lane),
    .tx_phy  (tx_phy),
    .rx_phy  (rx_phy)
  );

endmodule

/* design/phy_framer.sv */
`include "link_settings.svh"

module phy_framer (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  logic                link_up,
  phy_lane_if.framer          lane,
  output link_pkg::phy_word_t tx_phy,
  input  link_pkg::phy_word_t rx_phy
);

  link_pkg::phy_word_t tx_next;

  //////////////////////////////
  // Outgoing word
  //////////////////////////////

  // Data fields stay zero unless their push bit is set
  always_comb begin
    tx_next = '0;
    tx_next[`LINK_PHY_AW_PUSH] = lane.aw_push;
    if (lane.aw_push) begin
      tx_next[`LINK_PHY_AW_LSB +: `LINK_AW_WIDTH] = lane.aw_data;
    end
    tx_next[`LINK_PHY_W_PUSH] = lane.w_push;
    if (lane.w_push) begin
      tx_next[`LINK_PHY_W_LSB +: `LINK_W_WIDTH] = lane.w_data;
    end
    tx_next[`LINK_PHY_B_CREDIT] = lane.b_credit;
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !link_up) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_next;
    end
  end

  //////////////////////////////
  // Incoming word
  //////////////////////////////

  // Pulses are dropped while the link is down
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !link_up) begin
      lane.b_push    <= 1'b0;
      lane.b_data    <= '0;
      lane.aw_credit <= 1'b0;
      lane.w_credit  <= 1'b0;
    end else begin
      lane.b_push    <= rx_phy[`LINK_PHY_B_PUSH];
      lane.b_data    <= rx_phy[`LINK_PHY_B_LSB +: `LINK_B_WIDTH];
      lane.aw_credit <= rx_phy[`LINK_PHY_AW_CREDIT];
      lane.w_credit  <= rx_phy[`LINK_PHY_W_CREDIT];
    end
  end

endmodule

/* design/ll_receive.sv */
module ll_receive #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             link_up,

  // Link side
  input  logic             push,
  input  logic [WIDTH-1:0] data,

  // User side
  output logic             user_valid,
  output logic [WIDTH-1:0] user_data,
  input  logic             user_ready,

  // One pulse per popped entry
  output logic             credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  // Circular pointer advance
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign user_valid = (count != '0);
  assign user_data  = mem[rd_ptr];
  assign pop        = user_valid && user_ready;

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (push && link_up) begin
      mem[wr_ptr] <= data;
    end
  end

  //////////////////////////////
  // Pointers, occupancy, credit
  //////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !link_up) begin
      // Flush everything while the link is down
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
      credit <= pop;
    end
  end

endmodule

/* design/ll_transmit.sv */
module ll_transmit #(
  parameter int WIDTH = 8
) (
  input  logic              clk_wr,
  input  logic              rst_n,
  input  logic              link_up,
  input  link_pkg::credit_t init_credit,

  // User side
  input  logic              user_valid,
  input  logic [WIDTH-1:0]  user_data,
  output logic              user_ready,

  // Link side
  output logic              push,
  output logic [WIDTH-1:0]  data,
  input  logic              credit_return
);

  link_pkg::credit_t credit_cnt;
  logic              accept;

  // Far side has room for at least one more word
  assign user_ready = link_up && (credit_cnt != '0);
  assign accept     = user_valid && user_ready;

  //////////////////////////////
  // Credit counter
  //////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      credit_cnt <= '0;
    end else if (!link_up) begin
      credit_cnt <= init_credit;
    end else begin
      case ({accept, credit_return})
        2'b10:   credit_cnt <= credit_cnt - link_pkg::credit_t'(1);
        2'b01:   credit_cnt <= credit_cnt + link_pkg::credit_t'(1);
        default: credit_cnt <= credit_cnt;  // idle, or send and return cancel
      endcase
    end
  end

  //////////////////////////////
  // Push register
  //////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      push <= 1'b0;
    end else begin
      push <= accept;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (accept) begin
      data <= user_data;
    end
  end

endmodule

/* design/online_sync.sv */
module online_sync (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             tx_online,
  input  logic             rx_online,
  input  link_pkg::delay_t delay_value,
  output logic             link_up
);

  link_pkg::sync_state_t state;
  link_pkg::delay_t      hold_cnt;
  link_pkg::delay_t      next_cnt;
  logic                  both_online;

  assign both_online = tx_online && rx_online;
  assign next_cnt    = hold_cnt + link_pkg::delay_t'(1);

  // Count of consecutive cycles with both sides online
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !both_online) begin
      state    <= link_pkg::offline;
      hold_cnt <= '0;
    end else begin
      case (state)
        link_pkg::offline: begin
          hold_cnt <= link_pkg::delay_t'(1);
          // Zero or one cycle of hold-off goes straight up
          if (delay_value <= link_pkg::delay_t'(1)) begin
            state <= link_pkg::online;
          end else begin
            state <= link_pkg::holding;
          end
        end
        link_pkg::holding: begin
          hold_cnt <= next_cnt;
          if (next_cnt >= delay_value) begin
            state <= link_pkg::online;
          end
        end
        default: begin
          state <= link_pkg::online;
        end
      endcase
    end
  end

  assign link_up = (state == link_pkg::online);

endmodule

/* design/phy_lane_if.sv */
// Link channels as seen at the PHY framer
interface phy_lane_if;

  // Transmit channels toward the far side
  logic                aw_push;
  link_pkg::aw_word_t  aw_data;
  logic                w_push;
  link_pkg::w_word_t   w_data;

  // Credits coming back for our transmit channels
  logic                aw_credit;
  logic                w_credit;

  // Receive channel and its credit return
  logic                b_push;
  link_pkg::b_word_t   b_data;
  logic                b_credit;

  modport framer (
    input  aw_push, aw_data,
    input  w_push, w_data,
    input  b_credit,
    output aw_credit, w_credit,
    output b_push, b_data
  );

endinterface

/* design/link_pkg.sv */
`include "link_settings.svh"

package link_pkg;

  //////////////////////////////
  // Link word types
  //////////////////////////////

  // {id, size, len, burst, addr}
  typedef logic [`LINK_AW_WIDTH-1:0] aw_word_t;

  // {id, data, strb, last}
  typedef logic [`LINK_W_WIDTH-1:0] w_word_t;

  // {id, resp}
  typedef logic [`LINK_B_WIDTH-1:0] b_word_t;

  typedef logic [`LINK_PHY_WIDTH-1:0] phy_word_t;

  //////////////////////////////
  // Control types
  //////////////////////////////

  typedef logic [`LINK_CREDIT_WIDTH-1:0] credit_t;
  typedef logic [`LINK_DELAY_WIDTH-1:0] delay_t;

  // Link bring-up states
  typedef enum logic [1:0] {
    offline,
    holding,
    online
  } sync_state_t;

endpackage

/* design/link_settings.svh */
`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

// Word widths
`define LINK_AW_WIDTH      47
`define LINK_W_WIDTH       39
`define LINK_B_WIDTH       4
`define LINK_PHY_WIDTH     96
`define LINK_CREDIT_WIDTH  8
`define LINK_DELAY_WIDTH   16

// Receive FIFO depth for B
`define LINK_B_DEPTH       8

// Outgoing PHY word layout
`define LINK_PHY_AW_PUSH   0
`define LINK_PHY_AW_LSB    1
`define LINK_PHY_W_PUSH    48
`define LINK_PHY_W_LSB     49
`define LINK_PHY_B_CREDIT  88

// Incoming PHY word layout
`define LINK_PHY_B_PUSH    0
`define LINK_PHY_B_LSB     1
`define LINK_PHY_AW_CREDIT 5
`define LINK_PHY_W_CREDIT  6

`endif
